//--- include/fpm_settings.svh
/* widths, register offsets, alignment limit and iteration counts of the FPM exponent unit */

`ifndef FPM_SETTINGS_SVH
`define FPM_SETTINGS_SVH

// datapath widths
`define FPM_EXP_W       8
`define FPM_SUM_W       10
`define FPM_CNT_W       6

// exponent difference at which the T operand drops out of alignment
`define FPM_ALIGN_LIMIT 40

// fixed step counts of the iterative operations
`define FPM_ITER_MW     16
`define FPM_ITER_DW     17
`define FPM_ITER_MF     39
`define FPM_ITER_DF     40

// AXI4-Lite register map
`define FPM_REG_CMD     4'h0
`define FPM_REG_START   4'h4
`define FPM_REG_STATUS  4'h8
`define FPM_REG_COUNT   4'hC

`endif

//--- source/fpm_pkg.sv
/* opcode enum and the operation, command and result structs of the FPM unit */

`default_nettype none

`include "fpm_settings.svh"

package fpm_pkg;

	// fixed point 0..3, floating point 4..7
	typedef enum logic [2:0] {
		ad = 3'd0,
		sd = 3'd1,
		mw = 3'd2,
		dw = 3'd3,
		af = 3'd4,
		sf = 3'd5,
		mf = 3'd6,
		df = 3'd7
	} fpm_opcode_e;

	// one-hot decode plus operation groups
	typedef struct packed {
		logic ad;
		logic sd;
		logic mw;
		logic dw;
		logic af;
		logic sf;
		logic mf;
		logic df;
		logic ad_sd;
		logic af_sf;
		logic mw_mf;
		logic dw_df;
		logic ff;
	} fpm_op_t;

	// b_mode 0 inverted B, 1 true B, 2 all ones, 3 all zeros
	typedef struct packed {
		logic [1:0]            rsvd;
		fpm_opcode_e           opcode;
		logic [1:0]            b_mode;
		logic                  pc8;
		logic [`FPM_EXP_W-1:0] w;
		logic [`FPM_EXP_W-1:0] b;
	} fpm_cmd_t;

	typedef struct packed {
		logic [`FPM_SUM_W-1:0] sum;
		logic                  g;
		logic                  wdt;
		logic                  wt;
	} fpm_result_t;

endpackage

`default_nettype wire

//--- source/fpm_op_decoder.sv
/* opcode decoder: one-hot operation bits, operation groups and fixed iteration count */

`default_nettype none

`include "fpm_settings.svh"

module fpm_op_decoder (
	input  fpm_pkg::fpm_opcode_e  opcode,
	output fpm_pkg::fpm_op_t      op,
	output logic [`FPM_CNT_W-1:0] iter_count
);

	import fpm_pkg::*;

	always_comb begin
		op    = '0;
		op.ad = (opcode == ad);
		op.sd = (opcode == sd);
		op.mw = (opcode == mw);
		op.dw = (opcode == dw);
		op.af = (opcode == af);
		op.sf = (opcode == sf);
		op.mf = (opcode == mf);
		op.df = (opcode == df);

		// groups share one sequence in the control path
		op.ad_sd = op.ad | op.sd;
		op.af_sf = op.af | op.sf;
		op.mw_mf = op.mw | op.mf;
		op.dw_df = op.dw | op.df;

		// top opcode bit marks floating point
		op.ff = opcode[2];
	end

	// steps of the iterative multiply and divide
	always_comb begin
		case (opcode)
			mw:      iter_count = `FPM_CNT_W'(`FPM_ITER_MW);
			dw:      iter_count = `FPM_CNT_W'(`FPM_ITER_DW);
			mf:      iter_count = `FPM_CNT_W'(`FPM_ITER_MF);
			df:      iter_count = `FPM_CNT_W'(`FPM_ITER_DF);
			default: iter_count = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- source/fpm_exponent_unit.sv
/* exponent unit: D and B registers, B-bus modifier, 10-bit exponent adder
   and the alignment flags g, wdt and wt */

`default_nettype none

`include "fpm_settings.svh"

module fpm_exponent_unit (
	input  logic                  wdtwtg_clk,
	input  logic                  _0_f,
	input  fpm_pkg::fpm_cmd_t     cmd,
	input  fpm_pkg::fpm_op_t      op,
	input  logic                  load_regs,
	input  logic                  strobe_sum,
	output fpm_pkg::fpm_result_t  result,
	output logic [`FPM_CNT_W-1:0] align_count
);

	localparam int ext_w = `FPM_SUM_W - `FPM_EXP_W;

	logic [`FPM_SUM_W-1:0] d_reg;
	logic [`FPM_EXP_W-1:0] b_reg;
	logic [`FPM_SUM_W-1:0] b_bus;
	logic [`FPM_SUM_W-1:0] sum_c;
	logic [`FPM_SUM_W-1:0] sum_mag;
	logic                  sum_ge_limit;
	logic [`FPM_SUM_W-1:0] result_mag;

	// ------------------------------------------------------------
	// D and B registers
	// ------------------------------------------------------------

	// D takes w sign-extended to the sum width
	always_ff @(posedge wdtwtg_clk or posedge _0_f) begin
		if (_0_f) begin
			d_reg <= '0;
			b_reg <= '0;
		end else if (load_regs) begin
			d_reg <= {{ext_w{cmd.w[`FPM_EXP_W-1]}}, cmd.w};
			b_reg <= cmd.b;
		end
	end

	// ------------------------------------------------------------
	// B bus and exponent adder
	// ------------------------------------------------------------

	always_comb begin
		case (cmd.b_mode)
			// inverted B extends with its own inverted top bit
			2'd0:    b_bus = {{ext_w{~b_reg[`FPM_EXP_W-1]}}, ~b_reg};
			2'd1:    b_bus = {{ext_w{b_reg[`FPM_EXP_W-1]}}, b_reg};
			2'd2:    b_bus = '1;
			default: b_bus = '0;
		endcase
	end

	assign sum_c = d_reg + b_bus + `FPM_SUM_W'(cmd.pc8);

	// two's complement magnitude of the difference
	assign sum_mag      = sum_c[`FPM_SUM_W-1] ? -sum_c : sum_c;
	assign sum_ge_limit = (sum_mag >= `FPM_SUM_W'(`FPM_ALIGN_LIMIT));

	// ------------------------------------------------------------
	// sum and alignment flags
	// ------------------------------------------------------------

	always_ff @(posedge wdtwtg_clk or posedge _0_f) begin
		if (_0_f) begin
			result <= '0;
		end else if (strobe_sum) begin
			result.sum <= sum_c;
			if (op.af_sf) begin
				result.wdt <= sum_c[`FPM_SUM_W-1];
				result.g   <= sum_ge_limit;
				// T too small to matter so the result stays in T
				result.wt  <= sum_ge_limit & ~sum_c[`FPM_SUM_W-1];
			end else begin
				result.wdt <= 1'b0;
				result.g   <= 1'b0;
				result.wt  <= 1'b0;
			end
		end
	end

	// shift distance drops to zero once out of range
	assign result_mag  = result.sum[`FPM_SUM_W-1] ? -result.sum : result.sum;
	assign align_count = result.g ? '0 : result_mag[`FPM_CNT_W-1:0];

endmodule

`default_nettype wire

//--- source/fpm_step_sequencer.sv
/* phase sequencer and loadable step down-counter with busy output */

`default_nettype none

`include "fpm_settings.svh"

module fpm_step_sequencer (
	input  logic                  wdtwtg_clk,
	input  logic                  _0_f,
	input  logic                  start,
	input  fpm_pkg::fpm_op_t      op,
	input  logic [`FPM_CNT_W-1:0] iter_count,
	input  logic [`FPM_CNT_W-1:0] align_count,
	output logic                  load_regs,
	output logic                  strobe_sum,
	output logic                  busy,
	output logic [`FPM_CNT_W-1:0] count
);

	typedef enum logic [2:0] {
		ph_idle,
		ph_load,
		ph_sum,
		ph_fetch,
		ph_count
	} phase_e;

	phase_e                phase;
	logic [`FPM_CNT_W-1:0] load_value;

	// alignment distance for add and subtract, fixed steps otherwise
	always_comb begin
		if (op.af_sf)
			load_value = align_count;
		else if (op.mw_mf | op.dw_df)
			load_value = iter_count;
		else
			load_value = '0;
	end

	always_ff @(posedge wdtwtg_clk or posedge _0_f) begin
		if (_0_f) begin
			phase <= ph_idle;
			count <= '0;
		end else begin
			case (phase)
				// start only taken from idle
				ph_idle:  if (start) phase <= ph_load;
				ph_load:  phase <= ph_sum;
				ph_sum:   phase <= ph_fetch;
				ph_fetch: begin
					count <= load_value;
					phase <= ph_count;
				end
				ph_count: begin
					if (count == '0)
						phase <= ph_idle;
					else
						count <= count - `FPM_CNT_W'(1);
				end
				default:  phase <= ph_idle;
			endcase
		end
	end

	assign load_regs  = (phase == ph_load);
	assign strobe_sum = (phase == ph_sum);
	assign busy       = (phase != ph_idle);

endmodule

`default_nettype wire

//--- source/fpm_axil_regs.sv
/* AXI4-Lite slave: CMD register, START trigger, STATUS and COUNT readback */

`default_nettype none

`include "fpm_settings.svh"

module fpm_axil_regs (
	input  logic                  wdtwtg_clk,
	input  logic                  _0_f,
	// AXI4-Lite slave
	input  logic [3:0]            awaddr,
	input  logic                  awvalid,
	output logic                  awready,
	input  logic [31:0]           wdata,
	input  logic [3:0]            wstrb,
	input  logic                  wvalid,
	output logic                  wready,
	output logic [1:0]            bresp,
	output logic                  bvalid,
	input  logic                  bready,
	input  logic [3:0]            araddr,
	input  logic                  arvalid,
	output logic                  arready,
	output logic [31:0]           rdata,
	output logic [1:0]            rresp,
	output logic                  rvalid,
	input  logic                  rready,
	// unit side
	output fpm_pkg::fpm_cmd_t     cmd,
	output logic                  start,
	input  logic                  busy,
	input  fpm_pkg::fpm_result_t  result,
	input  logic [`FPM_CNT_W-1:0] count
);

	import fpm_pkg::*;

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;
	localparam int         cmd_w       = $bits(fpm_cmd_t);

	logic             wr_fire;
	logic             rd_fire;
	logic             wr_err;
	logic             rd_err;
	logic [cmd_w-1:0] cmd_wr;
	logic [31:0]      rd_word;
	logic [31:0]      status_word;

	// ------------------------------------------------------------
	// handshakes
	// ------------------------------------------------------------

	assign wr_fire = awvalid & wvalid & ~bvalid;
	assign awready = wr_fire;
	assign wready  = wr_fire;
	assign rd_fire = arvalid & ~rvalid;
	assign arready = rd_fire;

	// ------------------------------------------------------------
	// write path
	// ------------------------------------------------------------

	// command is frozen while a run is in progress
	always_comb begin
		case (awaddr)
			`FPM_REG_CMD, `FPM_REG_START: wr_err = busy;
			default:                      wr_err = 1'b1;
		endcase
	end

	// byte lanes of the command word
	always_comb begin
		cmd_wr = cmd;
		for (int i = 0; i < cmd_w / 8; i++) begin
			if (wstrb[i])
				cmd_wr[8*i +: 8] = wdata[8*i +: 8];
		end
	end

	always_ff @(posedge wdtwtg_clk or posedge _0_f) begin
		if (_0_f) begin
			cmd    <= '0;
			start  <= 1'b0;
			bvalid <= 1'b0;
			bresp  <= resp_okay;
		end else begin
			start <= wr_fire & ~wr_err & (awaddr == `FPM_REG_START);
			if (wr_fire) begin
				bvalid <= 1'b1;
				bresp  <= wr_err ? resp_slverr : resp_okay;
				if (~wr_err && awaddr == `FPM_REG_CMD)
					cmd <= fpm_cmd_t'(cmd_wr);
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------
	// read path
	// ------------------------------------------------------------

	assign status_word = {{(16 - `FPM_SUM_W){1'b0}}, result.sum, 12'd0,
		result.wt, result.wdt, result.g, busy};

	always_comb begin
		rd_err = 1'b0;
		case (araddr)
			`FPM_REG_CMD:    rd_word = {{(32 - cmd_w){1'b0}}, cmd};
			`FPM_REG_START:  rd_word = '0;
			`FPM_REG_STATUS: rd_word = status_word;
			`FPM_REG_COUNT:  rd_word = {{(32 - `FPM_CNT_W){1'b0}}, count};
			default: begin
				rd_word = '0;
				rd_err  = 1'b1;
			end
		endcase
	end

	// data held until rready
	always_ff @(posedge wdtwtg_clk or posedge _0_f) begin
		if (_0_f) begin
			rvalid <= 1'b0;
			rdata  <= '0;
			rresp  <= resp_okay;
		end else if (rd_fire) begin
			rvalid <= 1'b1;
			rdata  <= rd_word;
			rresp  <= rd_err ? resp_slverr : resp_okay;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- source/fpm_top.sv
/* FPM exponent and sequencing unit top level */

`default_nettype none

`include "fpm_settings.svh"

module fpm_top (
	input  logic        wdtwtg_clk,
	input  logic        _0_f,
	input  logic [3:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [3:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready
);

	import fpm_pkg::*;

	fpm_cmd_t              cmd;
	fpm_op_t               op;
	fpm_result_t           result;
	logic                  start;
	logic                  load_regs;
	logic                  strobe_sum;
	logic                  busy;
	logic [`FPM_CNT_W-1:0] iter_count;
	logic [`FPM_CNT_W-1:0] align_count;
	logic [`FPM_CNT_W-1:0] count;

	fpm_axil_regs u_regs (
		.wdtwtg_clk (wdtwtg_clk),
		._0_f       (_0_f),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.cmd        (cmd),
		.start      (start),
		.busy       (busy),
		.result     (result),
		.count      (count)
	);

	fpm_op_decoder u_dec (
		.opcode     (cmd.opcode),
		.op         (op),
		.iter_count (iter_count)
	);

	fpm_exponent_unit u_exp (
		.wdtwtg_clk  (wdtwtg_clk),
		._0_f        (_0_f),
		.cmd         (cmd),
		.op          (op),
		.load_regs   (load_regs),
		.strobe_sum  (strobe_sum),
		.result      (result),
		.align_count (align_count)
	);

	fpm_step_sequencer u_seq (
		.wdtwtg_clk  (wdtwtg_clk),
		._0_f        (_0_f),
		.start       (start),
		.op          (op),
		.iter_count  (iter_count),
		.align_count (align_count),
		.load_regs   (load_regs),
		.strobe_sum  (strobe_sum),
		.busy        (busy),
		.count       (count)
	);

endmodule

`default_nettype wire

//--- testbench/fpm_properties.sv
/* concurrent assertions on the AXI4-Lite responses and the step sequencer */

`default_nettype none

`include "fpm_settings.svh"

module fpm_properties (
	input logic                  wdtwtg_clk,
	input logic                  _0_f,
	input logic                  bvalid,
	input logic                  bready,
	input logic [1:0]            bresp,
	input logic                  rvalid,
	input logic                  rready,
	input logic [31:0]           rdata,
	input logic                  busy,
	input logic                  in_fetch,
	input logic [`FPM_CNT_W-1:0] count,
	input logic                  load_regs,
	input logic                  strobe_sum
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// write response held until taken
	assert property (@(posedge wdtwtg_clk) disable iff (_0_f)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else begin
			$error("bvalid or bresp changed before bready");
			fail_count++;
		end

	assert property (@(posedge wdtwtg_clk) disable iff (_0_f)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else begin
			$error("rvalid or rdata changed before rready");
			fail_count++;
		end

	// counter only loads upward in the fetch phase
	assert property (@(posedge wdtwtg_clk) disable iff (_0_f)
		busy && !in_fetch |=> count <= $past(count))
		else begin
			$error("step counter rose outside the fetch phase");
			fail_count++;
		end

	assert property (@(posedge wdtwtg_clk) disable iff (_0_f)
		!(load_regs && strobe_sum))
		else begin
			$error("load_regs and strobe_sum high together");
			fail_count++;
		end

endmodule

bind fpm_axil_regs fpm_properties u_axil_props (
	.wdtwtg_clk (wdtwtg_clk),
	._0_f       (_0_f),
	.bvalid     (bvalid),
	.bready     (bready),
	.bresp      (bresp),
	.rvalid     (rvalid),
	.rready     (rready),
	.rdata      (rdata),
	.busy       (1'b0),
	.in_fetch   (1'b0),
	.count      ('0),
	.load_regs  (1'b0),
	.strobe_sum (1'b0)
);

bind fpm_step_sequencer fpm_properties u_seq_props (
	.wdtwtg_clk (wdtwtg_clk),
	._0_f       (_0_f),
	.bvalid     (1'b0),
	.bready     (1'b0),
	.bresp      (2'b00),
	.rvalid     (1'b0),
	.rready     (1'b0),
	.rdata      (32'd0),
	.busy       (busy),
	.in_fetch   (phase == ph_fetch),
	.count      (count),
	.load_regs  (load_regs),
	.strobe_sum (strobe_sum)
);

`default_nettype wire

//--- testbench/fpm_tb.sv
/* testbench for the FPM exponent unit: clock, reset, AXI4-Lite driver tasks, LFSR,
   reference model, compare process, watchdog and report */

`default_nettype none

`include "fpm_settings.svh"

module fpm_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [1:0] okay   = 2'b00;
	localparam logic [1:0] slverr = 2'b10;

	// runs per test group
	localparam int n_dir       = 8;
	localparam int n_rand      = 16;
	localparam int n_iter      = 32;
	localparam int n_busy      = 2;
	localparam int n_stall     = 8;
	localparam int num_runs    = n_dir + n_rand + n_iter + n_busy + n_stall;
	localparam int watchdog_ns = num_runs * (3 + 40 + 20) * 8 + 4000;
	localparam int poll_limit  = 100;
	localparam int hs_limit    = 50;

	typedef struct packed {
		logic [`FPM_SUM_W-1:0] sum;
		logic                  g;
		logic                  wdt;
		logic                  wt;
		logic [`FPM_CNT_W-1:0] cnt;
	} expect_t;

	logic        wdtwtg_clk;
	logic        _0_f;
	logic [3:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [3:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;

	logic [15:0] lfsr;
	logic        stall_en;
	string       test_name;
	int          errors;
	int          test_err_start;
	int          tests_run;
	int          tests_failed;
	expect_t     exp_q[$];
	event        run_started;
	event        run_checked;

	fpm_top u_dut (
		.wdtwtg_clk (wdtwtg_clk),
		._0_f       (_0_f),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready)
	);

	initial wdtwtg_clk = 1'b0;
	always #4 wdtwtg_clk = ~wdtwtg_clk;

	// ------------------------------------------------------------
	// random numbers and reference model
	// ------------------------------------------------------------

	// Galois form with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		return s >> 1;
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[6:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	function automatic expect_t fpm_model(input logic [2:0] opc, input logic [1:0] bm,
			input logic pc8, input logic [7:0] w, input logic [7:0] b);
		expect_t e;
		int      d_val;
		int      b_val;
		int      s;
		int      mag;
		d_val = $signed(w);
		b_val = $signed(b);
		case (bm)
			2'd0:    b_val = -b_val - 1;
			2'd1:    b_val = b_val;
			2'd2:    b_val = -1;
			default: b_val = 0;
		endcase
		s   = d_val + b_val + int'(pc8);
		mag = (s < 0) ? -s : s;
		e     = '0;
		e.sum = s[`FPM_SUM_W-1:0];
		// flags and shift distance only for floating add and subtract
		if (opc == 3'd4 || opc == 3'd5) begin
			e.wdt = (s < 0);
			e.g   = (mag >= `FPM_ALIGN_LIMIT);
			e.wt  = e.g && (s >= 0);
			e.cnt = e.g ? '0 : mag[`FPM_CNT_W-1:0];
		end else begin
			case (opc)
				3'd2:    e.cnt = `FPM_CNT_W'(`FPM_ITER_MW);
				3'd3:    e.cnt = `FPM_CNT_W'(`FPM_ITER_DW);
				3'd6:    e.cnt = `FPM_CNT_W'(`FPM_ITER_MF);
				3'd7:    e.cnt = `FPM_CNT_W'(`FPM_ITER_DF);
				default: e.cnt = '0;
			endcase
		end
		return e;
	endfunction

	// ------------------------------------------------------------
	// reporting
	// ------------------------------------------------------------

	task automatic value_error(input string field, input logic [31:0] exp,
			input logic [31:0] act);
		$display("ERROR test %s %s: expected %0h, actual %0h", test_name, field, exp, act);
		errors++;
	endtask

	task automatic start_test(input string name);
		test_name      = name;
		test_err_start = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors != test_err_start) begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name, errors - test_err_start);
		end else begin
			$display("test %s: ok", test_name);
		end
	endtask

	// ------------------------------------------------------------
	// AXI4-Lite master tasks
	// ------------------------------------------------------------

	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int hold;
		int n;
		hold = stall_en ? int'(rand_bits(2)) : 0;
		@(posedge wdtwtg_clk);
		awaddr  <= addr;
		awvalid <= 1'b1;
		wdata   <= data;
		wstrb   <= 4'hF;
		wvalid  <= 1'b1;
		bready  <= (hold == 0);
		n = 0;
		do begin
			@(posedge wdtwtg_clk);
			n++;
		end while (!awready && n < hs_limit);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		if (!awready) begin
			$display("test %s: write to offset %0h was never accepted", test_name, addr);
			errors++;
		end
		// hold off the response for a few cycles
		repeat (hold) @(posedge wdtwtg_clk);
		bready <= 1'b1;
		n = 0;
		do begin
			@(posedge wdtwtg_clk);
			n++;
		end while (!(bvalid && bready) && n < hs_limit);
		resp = bresp;
		if (!(bvalid && bready)) begin
			$display("test %s: no write response for offset %0h", test_name, addr);
			errors++;
		end
	endtask

	task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int hold;
		int n;
		hold = stall_en ? int'(rand_bits(2)) : 0;
		@(posedge wdtwtg_clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		rready  <= (hold == 0);
		n = 0;
		do begin
			@(posedge wdtwtg_clk);
			n++;
		end while (!arready && n < hs_limit);
		arvalid <= 1'b0;
		if (!arready) begin
			$display("test %s: read of offset %0h was never accepted", test_name, addr);
			errors++;
		end
		repeat (hold) @(posedge wdtwtg_clk);
		rready <= 1'b1;
		n = 0;
		do begin
			@(posedge wdtwtg_clk);
			n++;
		end while (!(rvalid && rready) && n < hs_limit);
		data = rdata;
		resp = rresp;
		if (!(rvalid && rready)) begin
			$display("test %s: no read data for offset %0h", test_name, addr);
			errors++;
		end
	endtask

	// program one command, start it and hand the prediction to the compare process
	task automatic run_cmd(input logic [2:0] opc, input logic [1:0] bm, input logic pc8,
			input logic [7:0] w, input logic [7:0] b, input logic probe);
		expect_t     e;
		logic [31:0] word;
		logic [31:0] rd;
		logic [1:0]  resp;
		e    = fpm_model(opc, bm, pc8, w, b);
		word = {8'd0, 2'b00, opc, bm, pc8, w, b};
		axil_write(`FPM_REG_CMD, word, resp);
		if (resp !== okay)
			value_error("cmd bresp", 32'(okay), 32'(resp));
		axil_read(`FPM_REG_CMD, rd, resp);
		if (rd !== word)
			value_error("cmd readback", word, rd);
		axil_write(`FPM_REG_START, 32'd1, resp);
		if (resp !== okay)
			value_error("start bresp", 32'(okay), 32'(resp));
		if (probe) begin
			axil_write(`FPM_REG_START, 32'd1, resp);
			if (resp !== slverr)
				value_error("start while busy bresp", 32'(slverr), 32'(resp));
			axil_write(`FPM_REG_CMD, ~word & 32'h00FF_FFFF, resp);
			if (resp !== slverr)
				value_error("cmd while busy bresp", 32'(slverr), 32'(resp));
			axil_read(`FPM_REG_CMD, rd, resp);
			if (rd !== word)
				value_error("cmd after refused write", word, rd);
			// by now the counter is in its count phase
			axil_read(`FPM_REG_COUNT, rd, resp);
			if (rd > 32'(e.cnt))
				value_error("count during run", 32'(e.cnt), rd);
		end
		exp_q.push_back(e);
		-> run_started;
		@(run_checked);
	endtask

	// ------------------------------------------------------------
	// compare process
	// ------------------------------------------------------------

	initial begin : compare_results
		logic [31:0] word;
		logic [1:0]  resp;
		expect_t     e;
		int          polls;
		forever begin
			@(run_started);
			e     = exp_q.pop_front();
			polls = 0;
			do begin
				axil_read(`FPM_REG_STATUS, word, resp);
				polls++;
			end while (word[0] && polls < poll_limit);
			if (word[0]) begin
				$display("test %s: busy still high after %0d status reads", test_name, polls);
				errors++;
			end
			if (resp !== okay)
				value_error("status rresp", 32'(okay), 32'(resp));
			if (word[25:16] !== e.sum)
				value_error("sum", 32'(e.sum), 32'(word[25:16]));
			if (word[1] !== e.g)
				value_error("g", 32'(e.g), 32'(word[1]));
			if (word[2] !== e.wdt)
				value_error("wdt", 32'(e.wdt), 32'(word[2]));
			if (word[3] !== e.wt)
				value_error("wt", 32'(e.wt), 32'(word[3]));
			axil_read(`FPM_REG_COUNT, word, resp);
			if (word !== 32'd0)
				value_error("count after run", 32'd0, word);
			-> run_checked;
		end
	end

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------

	initial begin : stimulus
		logic [31:0] word;
		logic [1:0]  resp;
		logic [7:0]  w;
		logic [7:0]  b;
		logic [7:0]  r;
		logic [2:0]  opc;
		_0_f    = 1'b1;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b1;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b1;
		lfsr           = 16'd57526;
		stall_en       = 1'b0;
		errors         = 0;
		test_err_start = 0;
		tests_run      = 0;
		tests_failed   = 0;
		repeat (10) @(posedge wdtwtg_clk);
		_0_f <= 1'b0;

		start_test("reset_state");
		axil_read(`FPM_REG_STATUS, word, resp);
		if (word !== 32'd0)
			value_error("status", 32'd0, word);
		if (resp !== okay)
			value_error("status rresp", 32'(okay), 32'(resp));
		axil_read(`FPM_REG_COUNT, word, resp);
		if (word !== 32'd0)
			value_error("count", 32'd0, word);
		finish_test();

		start_test("unmapped_access");
		axil_read(4'h2, word, resp);
		if (resp !== slverr)
			value_error("unmapped rresp", 32'(slverr), 32'(resp));
		axil_write(`FPM_REG_STATUS, 32'hFFFF_FFFF, resp);
		if (resp !== slverr)
			value_error("read-only bresp", 32'(slverr), 32'(resp));
		axil_write(4'h6, 32'd1, resp);
		if (resp !== slverr)
			value_error("unmapped bresp", 32'(slverr), 32'(resp));
		axil_read(`FPM_REG_STATUS, word, resp);
		if (word !== 32'd0)
			value_error("status after refused writes", 32'd0, word);
		finish_test();

		// w minus b through inverted B with carry in
		start_test("float_directed");
		run_cmd(3'd4, 2'd0, 1'b1, 8'd49, 8'd10, 1'b0);
		run_cmd(3'd4, 2'd0, 1'b1, 8'd50, 8'd10, 1'b0);
		run_cmd(3'd5, 2'd0, 1'b1, 8'd10, 8'd49, 1'b0);
		run_cmd(3'd5, 2'd0, 1'b1, 8'd10, 8'd50, 1'b0);
		run_cmd(3'd4, 2'd0, 1'b1, 8'd100, 8'h9C, 1'b0);
		run_cmd(3'd5, 2'd0, 1'b1, 8'h9C, 8'd100, 1'b0);
		run_cmd(3'd4, 2'd1, 1'b0, 8'd20, 8'd21, 1'b0);
		run_cmd(3'd5, 2'd0, 1'b1, 8'h80, 8'h80, 1'b0);
		finish_test();

		start_test("float_random");
		for (int i = 0; i < n_rand; i++) begin
			w = rand_bits(8);
			r = rand_bits(6);
			// odd runs keep the exponents within about 32
			b = (i % 2 == 1) ? w + r - 8'd32 : rand_bits(8);
			r = rand_bits(4);
			opc = {2'b10, r[0]};
			if (i % 4 == 3)
				run_cmd(opc, r[2:1], r[3], w, b, 1'b0);
			else
				run_cmd(opc, 2'd0, 1'b1, w, b, 1'b0);
		end
		finish_test();

		start_test("iter_modes");
		for (int k = 0; k < 4; k++) begin
			opc = (k < 2) ? 3'(k + 2) : 3'(k + 4);
			for (int m = 0; m < 4; m++) begin
				for (int c = 0; c < 2; c++) begin
					w = rand_bits(8);
					b = rand_bits(8);
					run_cmd(opc, 2'(m), 1'(c), w, b, 1'b0);
				end
			end
		end
		finish_test();

		start_test("busy_reject");
		run_cmd(3'd6, 2'd0, 1'b1, 8'd90, 8'd30, 1'b1);
		run_cmd(3'd7, 2'd1, 1'b0, 8'hF0, 8'h11, 1'b1);
		finish_test();

		start_test("backpressure");
		stall_en = 1'b1;
		for (int i = 0; i < n_stall; i++) begin
			r = rand_bits(6);
			w = rand_bits(8);
			b = rand_bits(8);
			run_cmd(r[2:0], r[4:3], r[5], w, b, 1'b0);
		end
		stall_en = 1'b0;
		finish_test();

		// failed assertions in the bound checkers count as errors too
		errors = errors + u_dut.u_regs.u_axil_props.fail_count
			+ u_dut.u_seq.u_seq_props.fail_count;
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		#(watchdog_ns);
		$display("watchdog expired after %0d ns in test %s", watchdog_ns, test_name);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
source/fpm_pkg.sv
source/fpm_op_decoder.sv
source/fpm_exponent_unit.sv
source/fpm_step_sequencer.sv
source/fpm_axil_regs.sv
source/fpm_top.sv
testbench/fpm_properties.sv
testbench/fpm_tb.sv
